// ==== rtl/lc_reader_macros.svh ====
`ifndef LC_READER_MACROS_SVH
`define LC_READER_MACROS_SVH

////////////////////////////////////////////////////////////
// Port count and per-port memory region

// Ports served by this reader
`define LC_NUM_PORTS 4

// Width of a local port index
`define LC_PORT_BITS 2

// Word pointer inside one port region
`define LC_PTR_BITS 8

// Memory address is the port index above the word pointer
`define LC_ADDR_BITS (`LC_PORT_BITS + `LC_PTR_BITS)

////////////////////////////////////////////////////////////
// Word and frame fields

// Bytes in one memory or stream word
`define LC_WORD_BYTES 8
`define LC_DATA_BITS (`LC_WORD_BYTES * 8)

// Header word fields
`define LC_LEN_BITS 11
`define LC_VLAN_BITS 12
`define LC_MAC_BITS 48

// Global destination port from the MAC table
`define LC_DST_PORT_BITS 6

// Reads allowed in flight at once
`define LC_TAG_FIFO_DEPTH 8

`endif

// ==== rtl/lc_reader_pkg.sv ====
`include "lc_reader_macros.svh"

package lc_reader_pkg;

	////////////////////////////////////////////////////////////
	// Enumerations

	// Progress of the frame at the head of one port region
	typedef enum logic [2:0] {
		IDLE,
		DATA_READY,
		HEADER_WAIT,
		WORD0_WAIT,
		WORD1_WAIT,
		LOOKUP,
		FWD_READY,
		FORWARDING
	} port_state_e;

	// Why a memory read was issued
	typedef enum logic [1:0] {
		HEADER,
		WORD0,
		WORD1,
		BODY
	} rd_tag_e;

	////////////////////////////////////////////////////////////
	// Packed structs

	// One entry of the read tag FIFO
	typedef struct packed {
		rd_tag_e tag;
		logic [`LC_PORT_BITS-1:0] port;
	} rd_tag_t;

	// Request to the MAC table
	typedef struct packed {
		logic [`LC_VLAN_BITS-1:0] vlan;
		logic [`LC_MAC_BITS-1:0] dst_mac;
		logic [`LC_MAC_BITS-1:0] src_mac;
		logic [`LC_PORT_BITS-1:0] src_port;
	} lookup_req_t;

	// Answer from the MAC table
	typedef struct packed {
		logic hit;
		logic [`LC_DST_PORT_BITS-1:0] dst_port;
	} lookup_resp_t;

	// Everything captured about the current frame of a port
	typedef struct packed {
		logic [`LC_LEN_BITS-1:0] len;
		logic [`LC_VLAN_BITS-1:0] vlan;
		logic bcast;
		logic [`LC_DST_PORT_BITS-1:0] dst_port;
		logic [`LC_DATA_BITS-1:0] word0;
		logic [`LC_DATA_BITS-1:0] word1;
	} frame_info_t;

	// One word on the output stream
	typedef struct packed {
		logic [`LC_DATA_BITS-1:0] data;
		logic [`LC_WORD_BYTES-1:0] strb;
		logic last;
		logic [`LC_DST_PORT_BITS:0] dest;
		logic [`LC_VLAN_BITS-1:0] user;
	} stream_word_t;

endpackage

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             wr,
	input  logic [WIDTH-1:0] din,
	input  logic             rd,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	// Writes into a full FIFO and reads from an empty one are dropped
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

	// Head entry is always visible
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap at DEPTH so any depth works
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== rtl/frame_scheduler.sv ====
`timescale 1ns/1ps
`include "lc_reader_macros.svh"

module frame_scheduler import lc_reader_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [`LC_NUM_PORTS-1:0][`LC_PTR_BITS-1:0] wr_ptr_committed,
	input  logic tag_full,
	input  logic follow_req,
	input  logic [`LC_PORT_BITS-1:0] follow_port,
	input  rd_tag_e follow_tag,
	input  logic lookup_ready_valid,
	input  logic [`LC_PORT_BITS-1:0] lookup_ready_port,
	input  frame_info_t sel_info,
	input  logic frame_done,
	output logic rd_en,
	output logic [`LC_ADDR_BITS-1:0] rd_addr,
	output rd_tag_t rd_tag,
	output logic fwd_start,
	output logic [`LC_PORT_BITS-1:0] sel_port
);

	// Forwarding engine handles one frame at a time
	typedef enum logic [1:0] {
		FWD_IDLE,
		FWD_HEADER,
		FWD_BODY
	} fwd_state_e;

	port_state_e state [`LC_NUM_PORTS];
	logic [`LC_PTR_BITS-1:0] rd_ptr [`LC_NUM_PORTS];
	logic [`LC_NUM_PORTS-1:0] follow_pend;
	logic [`LC_PORT_BITS-1:0] rr_port;
	logic [`LC_PORT_BITS-1:0] sel_port_q;
	fwd_state_e fwd_state;
	logic [`LC_LEN_BITS-1:0] body_left;
	logic [`LC_LEN_BITS-1:0] len_words;

	logic follow_go;
	logic body_go;
	logic hdr_go;
	logic fwd_go;
	logic rr_slot;
	logic [`LC_PORT_BITS-1:0] go_port;
	rd_tag_e go_tag;

	// Frame length in whole words, rounded up
	assign len_words = (sel_info.len + `LC_LEN_BITS'(`LC_WORD_BYTES - 1))
		/ `LC_LEN_BITS'(`LC_WORD_BYTES);

	assign sel_port = sel_port_q;

	////////////////////////////////////////////////////////////
	// Read arbitration

	always_comb begin
		follow_go = 1'b0;
		go_port = rr_port;
		go_tag = HEADER;
		// Lowest numbered pending follow-up wins
		for (int i = `LC_NUM_PORTS - 1; i >= 0; i--) begin
			if (follow_pend[i]) begin
				follow_go = 1'b1;
				go_port = `LC_PORT_BITS'(i);
				go_tag = (state[i] == WORD0_WAIT) ? WORD0 : WORD1;
			end
		end
		// Body words of the frame being forwarded come next
		body_go = !follow_go && (fwd_state == FWD_BODY) && (body_left != '0);
		if (body_go) begin
			go_port = sel_port_q;
			go_tag = BODY;
		end
		// Round robin only gets the cycles nobody else wants
		rr_slot = !follow_go && !body_go;
		hdr_go = rr_slot && (state[rr_port] == DATA_READY);
		fwd_go = rr_slot && (state[rr_port] == FWD_READY) && (fwd_state == FWD_IDLE);
	end

	// Nothing goes out while every tag slot is taken
	assign rd_en = !tag_full && (follow_go || body_go || hdr_go);
	assign rd_addr = {go_port, rd_ptr[go_port]};
	assign rd_tag = '{tag: go_tag, port: go_port};

	////////////////////////////////////////////////////////////
	// Port table, pointers and forwarding

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LC_NUM_PORTS; i++) begin
				state[i] <= IDLE;
				rd_ptr[i] <= '0;
			end
			follow_pend <= '0;
			rr_port <= '0;
			fwd_state <= FWD_IDLE;
			fwd_start <= 1'b0;
			sel_port_q <= '0;
			body_left <= '0;
		end else begin
			fwd_start <= 1'b0;

			// Any idle port with committed words has a frame waiting
			for (int i = 0; i < `LC_NUM_PORTS; i++) begin
				if ((state[i] == IDLE) && (wr_ptr_committed[i] != rd_ptr[i]))
					state[i] <= DATA_READY;
			end

			// Issued read consumes one word of the port region
			if (rd_en) begin
				rd_ptr[go_port] <= rd_ptr[go_port] + 1'b1;
				case (go_tag)
					HEADER: state[go_port] <= HEADER_WAIT;
					WORD0: follow_pend[go_port] <= 1'b0;
					WORD1: begin
						follow_pend[go_port] <= 1'b0;
						// Lookup goes out once this word returns
						state[go_port] <= LOOKUP;
					end
					default: body_left <= body_left - 1'b1;
				endcase
			end

			// Follow-up wanted by the parser
			// The WAIT state then names the word still to fetch
			if (follow_req) begin
				follow_pend[follow_port] <= 1'b1;
				state[follow_port] <= (follow_tag == WORD0) ? WORD0_WAIT : WORD1_WAIT;
			end

			if (lookup_ready_valid)
				state[lookup_ready_port] <= FWD_READY;

			if (rr_slot)
				rr_port <= (rr_port == `LC_PORT_BITS'(`LC_NUM_PORTS - 1)) ? '0 : rr_port + 1'b1;

			// Start forwarding a port whose lookup has finished
			if (fwd_go) begin
				fwd_start <= 1'b1;
				fwd_state <= FWD_HEADER;
				sel_port_q <= rr_port;
				state[rr_port] <= FORWARDING;
			end

			case (fwd_state)
				FWD_HEADER: begin
					// Words 0 and 1 were read during the header phase
					if (fwd_start)
						body_left <= len_words - `LC_LEN_BITS'(2);
					else
						fwd_state <= FWD_BODY;
				end
				FWD_BODY: begin
					if (frame_done) begin
						fwd_state <= FWD_IDLE;
						state[sel_port_q] <= IDLE;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/header_parser.sv ====
`timescale 1ns/1ps
`include "lc_reader_macros.svh"

module header_parser import lc_reader_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rd_valid,
	input  logic [`LC_DATA_BITS-1:0] rd_data,
	input  rd_tag_t head_tag,
	input  logic lookup_done,
	input  lookup_resp_t lookup_resp,
	input  logic [`LC_PORT_BITS-1:0] sel_port,
	output logic follow_req,
	output logic [`LC_PORT_BITS-1:0] follow_port,
	output rd_tag_e follow_tag,
	output logic lookup_en,
	output lookup_req_t lookup_req,
	output logic lookup_ready_valid,
	output logic [`LC_PORT_BITS-1:0] lookup_ready_port,
	output frame_info_t sel_info,
	output logic body_valid,
	output logic [`LC_DATA_BITS-1:0] body_data
);

	frame_info_t info [`LC_NUM_PORTS];

	// First sixteen frame bytes once word 1 has arrived
	logic [2*`LC_DATA_BITS-1:0] frame_head;

	// MAC address starting at a frame byte
	// Lower byte index lands in the more significant byte
	function automatic logic [`LC_MAC_BITS-1:0] mac_at(
		input logic [2*`LC_DATA_BITS-1:0] bytes,
		input int first
	);
		logic [`LC_MAC_BITS-1:0] mac;
		for (int k = 0; k < `LC_MAC_BITS / 8; k++)
			mac[`LC_MAC_BITS-1-8*k -: 8] = bytes[(first+k)*8 +: 8];
		return mac;
	endfunction

	assign frame_head = {rd_data, info[head_tag.port].word0};

	////////////////////////////////////////////////////////////
	// Response decode

	// Header and word 0 each ask for the next word
	assign follow_req = rd_valid && ((head_tag.tag == HEADER) || (head_tag.tag == WORD0));
	assign follow_port = head_tag.port;
	assign follow_tag = (head_tag.tag == HEADER) ? WORD0 : WORD1;

	// Body words go straight on to the emitter
	assign body_valid = rd_valid && (head_tag.tag == BODY);
	assign body_data = rd_data;

	assign sel_info = info[sel_port];

	// Lookup answers come back in request order
	assign lookup_ready_valid = lookup_done;

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			case (head_tag.tag)
				HEADER: begin
					info[head_tag.port].len <= rd_data[`LC_LEN_BITS-1:0];
					info[head_tag.port].vlan <= rd_data[16 +: `LC_VLAN_BITS];
				end
				WORD0: info[head_tag.port].word0 <= rd_data;
				WORD1: info[head_tag.port].word1 <= rd_data;
				default: ;
			endcase
		end
		// Missed lookups are flooded
		if (lookup_done) begin
			info[lookup_ready_port].bcast <= !lookup_resp.hit;
			info[lookup_ready_port].dst_port <= lookup_resp.dst_port;
		end
		// Request built from the stored word 0 and the word 1 on the bus
		lookup_req <= '{
			vlan: info[head_tag.port].vlan,
			dst_mac: mac_at(frame_head, 0),
			src_mac: mac_at(frame_head, 6),
			src_port: head_tag.port
		};
	end

	always_ff @(posedge clk) begin
		if (reset)
			lookup_en <= 1'b0;
		else
			lookup_en <= rd_valid && (head_tag.tag == WORD1);
	end

	////////////////////////////////////////////////////////////
	// Ports with a lookup in flight

	// A port has at most one lookup outstanding
	sync_fifo #(
		.WIDTH(`LC_PORT_BITS),
		.DEPTH(`LC_NUM_PORTS)
	) lookup_port_fifo (
		.clk(clk),
		.reset(reset),
		.wr(lookup_en),
		.din(lookup_req.src_port),
		.rd(lookup_done),
		.dout(lookup_ready_port),
		.empty(),
		.full()
	);

endmodule

// ==== rtl/frame_emitter.sv ====
`timescale 1ns/1ps
`include "lc_reader_macros.svh"

module frame_emitter import lc_reader_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic fwd_start,
	input  frame_info_t start_info,
	input  logic body_valid,
	input  logic [`LC_DATA_BITS-1:0] body_data,
	output logic stream_valid,
	output stream_word_t stream,
	output logic frame_done
);

	frame_info_t info_q;
	frame_info_t cur;
	logic send_w1;
	logic [`LC_LEN_BITS-1:0] bytes_left;
	logic is_final;
	logic [`LC_WORD_BYTES-1:0] final_strb;

	// Info of the frame in flight, or of the one starting now
	assign cur = fwd_start ? start_info : info_q;

	// Words 0 and 1 never end a frame of legal length
	assign is_final = body_valid && (bytes_left <= `LC_LEN_BITS'(`LC_WORD_BYTES));

	// Low bytes_left bits set on the closing word
	assign final_strb = {`LC_WORD_BYTES{1'b1}} >> (`LC_WORD_BYTES - bytes_left);

	always_ff @(posedge clk) begin
		if (fwd_start)
			info_q <= start_info;

		// Word source follows the frame phase
		if (fwd_start)
			stream.data <= start_info.word0;
		else if (send_w1)
			stream.data <= info_q.word1;
		else
			stream.data <= body_data;

		stream.strb <= is_final ? final_strb : '1;
		stream.dest <= {cur.bcast, cur.dst_port};
		stream.user <= cur.vlan;

		if (reset) begin
			stream_valid <= 1'b0;
			stream.last <= 1'b0;
			frame_done <= 1'b0;
			send_w1 <= 1'b0;
			bytes_left <= '0;
		end else begin
			stream_valid <= fwd_start || send_w1 || body_valid;
			stream.last <= is_final;
			frame_done <= is_final;
			// Word 1 follows word 0 on the next cycle
			send_w1 <= fwd_start;

			// Bytes still to send after the word going out now
			if (fwd_start)
				bytes_left <= start_info.len - `LC_LEN_BITS'(`LC_WORD_BYTES);
			else if (send_w1 || body_valid)
				bytes_left <= bytes_left - `LC_LEN_BITS'(`LC_WORD_BYTES);
		end
	end

endmodule

// ==== rtl/lc_fifo_reader.sv ====
`timescale 1ns/1ps
`include "lc_reader_macros.svh"

module lc_fifo_reader import lc_reader_pkg::*; (
	input  logic clk,
	input  logic reset,

	// Committed write pointer of every port region
	input  logic [`LC_NUM_PORTS-1:0][`LC_PTR_BITS-1:0] wr_ptr_committed,

	// Memory read port
	output logic rd_en,
	output logic [`LC_ADDR_BITS-1:0] rd_addr,
	input  logic rd_valid,
	input  logic [`LC_DATA_BITS-1:0] rd_data,

	// MAC table
	output logic lookup_en,
	output lookup_req_t lookup_req,
	input  logic lookup_done,
	input  lookup_resp_t lookup_resp,

	// Output stream
	output logic stream_valid,
	output stream_word_t stream
);

	rd_tag_t rd_tag;
	rd_tag_t head_tag;
	logic tag_empty;
	logic tag_full;

	logic follow_req;
	logic [`LC_PORT_BITS-1:0] follow_port;
	rd_tag_e follow_tag;
	logic lookup_ready_valid;
	logic [`LC_PORT_BITS-1:0] lookup_ready_port;

	logic fwd_start;
	logic [`LC_PORT_BITS-1:0] sel_port;
	frame_info_t sel_info;
	logic frame_done;
	logic body_valid;
	logic [`LC_DATA_BITS-1:0] body_data;

	////////////////////////////////////////////////////////////
	// Read tags

	// One entry per read in flight, popped as each response returns
	sync_fifo #(
		.WIDTH($bits(rd_tag_t)),
		.DEPTH(`LC_TAG_FIFO_DEPTH)
	) tag_fifo (
		.clk(clk),
		.reset(reset),
		.wr(rd_en),
		.din(rd_tag),
		.rd(rd_valid),
		.dout(head_tag),
		.empty(tag_empty),
		.full(tag_full)
	);

	////////////////////////////////////////////////////////////
	// Stages

	frame_scheduler sched (
		.clk(clk),
		.reset(reset),
		.wr_ptr_committed(wr_ptr_committed),
		.tag_full(tag_full),
		.follow_req(follow_req),
		.follow_port(follow_port),
		.follow_tag(follow_tag),
		.lookup_ready_valid(lookup_ready_valid),
		.lookup_ready_port(lookup_ready_port),
		.sel_info(sel_info),
		.frame_done(frame_done),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_tag(rd_tag),
		.fwd_start(fwd_start),
		.sel_port(sel_port)
	);

	header_parser parser (
		.clk(clk),
		.reset(reset),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.head_tag(head_tag),
		.lookup_done(lookup_done),
		.lookup_resp(lookup_resp),
		.sel_port(sel_port),
		.follow_req(follow_req),
		.follow_port(follow_port),
		.follow_tag(follow_tag),
		.lookup_en(lookup_en),
		.lookup_req(lookup_req),
		.lookup_ready_valid(lookup_ready_valid),
		.lookup_ready_port(lookup_ready_port),
		.sel_info(sel_info),
		.body_valid(body_valid),
		.body_data(body_data)
	);

	frame_emitter emitter (
		.clk(clk),
		.reset(reset),
		.fwd_start(fwd_start),
		.start_info(sel_info),
		.body_valid(body_valid),
		.body_data(body_data),
		.stream_valid(stream_valid),
		.stream(stream),
		.frame_done(frame_done)
	);

endmodule

// ==== verification/lc_fifo_reader_props.sv ====
`timescale 1ns/1ps
`include "lc_reader_macros.svh"

module lc_fifo_reader_props
	import lc_reader_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic rd_en,
	input logic rd_valid,
	input logic tag_empty,
	input logic lookup_en,
	input logic stream_valid,
	input stream_word_t stream
);

	// Strobe plus one clears every bit of a run that starts at bit 0
	logic [`LC_WORD_BYTES-1:0] strb_plus_one;

	assign strb_plus_one = stream.strb + 1'b1;

	////////////////////////////////////////////////////////////
	// Output stream

	last_needs_valid: assert property (@(posedge clk) disable iff (reset)
		stream.last |-> stream_valid)
		else $error("stream.last without stream_valid");

	strobe_from_bit0: assert property (@(posedge clk) disable iff (reset)
		stream_valid |-> (stream.strb != '0) && ((stream.strb & strb_plus_one) == '0))
		else $error("stream.strb %h is empty or has a gap", stream.strb);

	////////////////////////////////////////////////////////////
	// Memory side and reset

	// Each response pops a tag that must already be there
	response_has_tag: assert property (@(posedge clk) disable iff (reset)
		rd_valid |-> !tag_empty)
		else $error("rd_valid with the tag FIFO empty");

	quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !rd_en && !lookup_en && !stream_valid)
		else $error("outputs active on the first cycle after reset");

endmodule

bind lc_fifo_reader lc_fifo_reader_props props (
	.clk(clk),
	.reset(reset),
	.rd_en(rd_en),
	.rd_valid(rd_valid),
	.tag_empty(tag_empty),
	.lookup_en(lookup_en),
	.stream_valid(stream_valid),
	.stream(stream)
);

// ==== verification/lc_fifo_reader_tb.sv ====
`timescale 1ns/1ps
`include "lc_reader_macros.svh"

module lc_fifo_reader_tb
	import lc_reader_pkg::*;
();

	localparam int NUM_FRAMES = 5;
	localparam int MAX_BYTES = 128;
	localparam int QUIET_CYCLES = 20;
	localparam int MEM_WORDS = 1 << `LC_ADDR_BITS;

	// One row of the frame table
	typedef struct packed {
		logic [`LC_PORT_BITS-1:0] port;
		logic [`LC_LEN_BITS-1:0] len;
		logic [`LC_VLAN_BITS-1:0] vlan;
		logic hit;
		logic [`LC_DST_PORT_BITS-1:0] dst;
	} frame_entry_t;

	logic clk = 1'b0;
	logic reset;
	logic [`LC_NUM_PORTS-1:0][`LC_PTR_BITS-1:0] wr_ptr_committed;
	logic rd_en;
	logic [`LC_ADDR_BITS-1:0] rd_addr;
	logic rd_valid;
	logic [`LC_DATA_BITS-1:0] rd_data;
	logic lookup_en;
	lookup_req_t lookup_req;
	logic lookup_done;
	lookup_resp_t lookup_resp;
	logic stream_valid;
	stream_word_t stream;

	// Frame table and the payload generated for each row
	frame_entry_t frames [NUM_FRAMES];
	logic [7:0] payload [NUM_FRAMES][MAX_BYTES];
	logic [`LC_DATA_BITS-1:0] mem [MEM_WORDS];
	int wp [`LC_NUM_PORTS];
	integer seed = 2743;

	// Progress of each frame on the output
	bit emitted [NUM_FRAMES];
	int word_count [NUM_FRAMES];
	int lookups [NUM_FRAMES];
	int frame_err [NUM_FRAMES];
	int frames_done = 0;

	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errs_before;
	int total_words;
	int limit_cycles = 0;
	int cyc = 0;

	// Memory pipeline, two stages deep
	logic p1_valid;
	logic p2_valid;
	logic [`LC_DATA_BITS-1:0] p1_data;
	logic [`LC_DATA_BITS-1:0] p2_data;

	// Lookups waiting for their answer
	int lk_due [$];
	logic [`LC_VLAN_BITS-1:0] lk_vlan [$];
	int lk_entry;

	lc_fifo_reader DUT (
		.clk(clk),
		.reset(reset),
		.wr_ptr_committed(wr_ptr_committed),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.lookup_en(lookup_en),
		.lookup_req(lookup_req),
		.lookup_done(lookup_done),
		.lookup_resp(lookup_resp),
		.stream_valid(stream_valid),
		.stream(stream)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic int words_of(input logic [`LC_LEN_BITS-1:0] len);
		return (int'(len) + 7) / 8;
	endfunction

	function automatic int find_frame(input logic [`LC_VLAN_BITS-1:0] vlan);
		for (int e = 0; e < NUM_FRAMES; e++)
			if (frames[e].vlan == vlan)
				return e;
		return -1;
	endfunction

	// Byte 0 of the word sits in the low byte
	function automatic logic [63:0] expected_word(input int e, input int idx);
		logic [63:0] w;
		for (int b = 0; b < 8; b++)
			w[b*8 +: 8] = payload[e][idx*8 + b];
		return w;
	endfunction

	// Low ((len - 1) mod 8) + 1 bits
	function automatic logic [7:0] last_strobe(input logic [`LC_LEN_BITS-1:0] len);
		int n;
		n = ((int'(len) - 1) % 8) + 1;
		return 8'((1 << n) - 1);
	endfunction

	task automatic note_mismatch(input string sig, input int e, input logic [63:0] got,
		input logic [63:0] exp);
		$display("FAILED %s: got %h expected %h", sig, got, exp);
		error_count++;
		if (e >= 0)
			frame_err[e]++;
	endtask

	task automatic note_problem(input string what, input int e);
		$display("ERROR %s", what);
		error_count++;
		if (e >= 0)
			frame_err[e]++;
	endtask

	// Header word, then payload words, then the new write pointer
	task automatic load_frame(input int e);
		int p;
		int nw;
		logic [63:0] word;
		p = frames[e].port;
		nw = words_of(frames[e].len);
		word = '0;
		word[`LC_LEN_BITS-1:0] = frames[e].len;
		word[16 +: `LC_VLAN_BITS] = frames[e].vlan;
		mem[{`LC_PORT_BITS'(p), `LC_PTR_BITS'(wp[p])}] = word;
		wp[p] = (wp[p] + 1) % (1 << `LC_PTR_BITS);
		for (int w = 0; w < nw; w++) begin
			for (int b = 0; b < 8; b++) begin
				payload[e][w*8 + b] = 8'($random(seed));
				word[b*8 +: 8] = payload[e][w*8 + b];
			end
			mem[{`LC_PORT_BITS'(p), `LC_PTR_BITS'(wp[p])}] = word;
			wp[p] = (wp[p] + 1) % (1 << `LC_PTR_BITS);
		end
	endtask

	task automatic check_lookup(input lookup_req_t req);
		int e;
		logic [47:0] dmac;
		logic [47:0] smac;
		e = find_frame(req.vlan);
		if (e < 0) begin
			note_problem($sformatf("lookup request carries unknown VLAN %h", req.vlan), -1);
			return;
		end
		lookups[e]++;
		// Lower byte index is the more significant MAC byte
		dmac = {payload[e][0], payload[e][1], payload[e][2],
			payload[e][3], payload[e][4], payload[e][5]};
		smac = {payload[e][6], payload[e][7], payload[e][8],
			payload[e][9], payload[e][10], payload[e][11]};
		if (req.dst_mac !== dmac)
			note_mismatch($sformatf("lookup_req.dst_mac frame %0d", e), e, req.dst_mac, dmac);
		if (req.src_mac !== smac)
			note_mismatch($sformatf("lookup_req.src_mac frame %0d", e), e, req.src_mac, smac);
		if (req.src_port !== frames[e].port)
			note_mismatch($sformatf("lookup_req.src_port frame %0d", e), e,
				req.src_port, frames[e].port);
	endtask

	task automatic finish_frame(input int e);
		emitted[e] = 1'b1;
		frames_done++;
		if (lookups[e] != 1)
			note_problem($sformatf("frame %0d had %0d lookups instead of one", e, lookups[e]), e);
		tests_run++;
		if (frame_err[e] == 0) begin
			$display("test frame %0d port %0d len %0d: passed", e, frames[e].port, frames[e].len);
		end else begin
			tests_failed++;
			$display("test frame %0d port %0d len %0d: failed with %0d errors",
				e, frames[e].port, frames[e].len, frame_err[e]);
		end
	endtask

	// Frames are told apart by their VLAN in user
	task automatic check_stream_word(input stream_word_t w);
		int e;
		int idx;
		int nw;
		logic [63:0] exp_data;
		logic [7:0] exp_strb;
		logic exp_last;
		logic [`LC_DST_PORT_BITS:0] exp_dest;
		e = find_frame(w.user);
		if (e < 0) begin
			note_problem($sformatf("stream word with unknown VLAN %h", w.user), -1);
			return;
		end
		if (emitted[e]) begin
			note_problem($sformatf("frame %0d sent a word after its last word", e), e);
			return;
		end
		idx = word_count[e];
		nw = words_of(frames[e].len);
		// Earlier frames of the same port must already be out
		if (idx == 0) begin
			for (int j = 0; j < e; j++)
				if (frames[j].port == frames[e].port && !emitted[j])
					note_problem($sformatf("frame %0d started before frame %0d of port %0d",
						e, j, frames[e].port), e);
		end
		exp_data = expected_word(e, idx);
		exp_last = (idx == nw - 1);
		exp_strb = exp_last ? last_strobe(frames[e].len) : 8'hff;
		exp_dest = {!frames[e].hit, frames[e].dst};
		if (w.data !== exp_data)
			note_mismatch($sformatf("stream.data frame %0d word %0d", e, idx), e,
				w.data, exp_data);
		if (w.strb !== exp_strb)
			note_mismatch($sformatf("stream.strb frame %0d word %0d", e, idx), e,
				w.strb, exp_strb);
		if (w.last !== exp_last)
			note_mismatch($sformatf("stream.last frame %0d word %0d", e, idx), e,
				w.last, exp_last);
		if (w.dest !== exp_dest)
			note_mismatch($sformatf("stream.dest frame %0d word %0d", e, idx), e,
				w.dest, exp_dest);
		word_count[e]++;
		if (exp_last || w.last)
			finish_frame(e);
	endtask

	////////////////////////////////////////////////////////////
	// Memory and lookup models

	always @(posedge clk) begin
		if (reset) begin
			p1_valid <= 1'b0;
			p2_valid <= 1'b0;
		end else begin
			p1_valid <= rd_en;
			p2_valid <= p1_valid;
		end
		p1_data <= mem[rd_addr];
		p2_data <= p1_data;
	end

	// Response reaches the DUT two edges after the request
	always @(negedge clk) begin
		rd_valid <= p2_valid;
		rd_data <= p2_data;
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (!reset && lookup_en) begin
			check_lookup(lookup_req);
			lk_due.push_back(cyc + 3);
			lk_vlan.push_back(lookup_req.vlan);
		end
	end

	// Answers in order, three edges after each request
	always @(negedge clk) begin
		lookup_done <= 1'b0;
		if (lk_due.size() > 0 && lk_due[0] == cyc + 1) begin
			lk_entry = find_frame(lk_vlan[0]);
			lookup_done <= 1'b1;
			if (lk_entry >= 0)
				lookup_resp <= '{hit: frames[lk_entry].hit, dst_port: frames[lk_entry].dst};
			else
				lookup_resp <= '0;
			void'(lk_due.pop_front());
			void'(lk_vlan.pop_front());
		end
	end

	always @(posedge clk) begin
		if (!reset && stream_valid)
			check_stream_word(stream);
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		reset = 1'b1;
		wr_ptr_committed = '0;
		rd_valid = 1'b0;
		rd_data = '0;
		lookup_done = 1'b0;
		lookup_resp = '0;

		// port, length, VLAN, hit, destination
		frames[0] = '{2'd0, 11'd17, 12'h101, 1'b1, 6'd12};
		frames[1] = '{2'd1, 11'd64, 12'h202, 1'b0, 6'd0};
		frames[2] = '{2'd2, 11'd120, 12'h303, 1'b1, 6'd45};
		frames[3] = '{2'd3, 11'd40, 12'h404, 1'b1, 6'd7};
		frames[4] = '{2'd2, 11'd58, 12'h505, 1'b0, 6'd3};

		for (int e = 0; e < NUM_FRAMES; e++) begin
			emitted[e] = 1'b0;
			word_count[e] = 0;
			lookups[e] = 0;
			frame_err[e] = 0;
		end
		for (int p = 0; p < `LC_NUM_PORTS; p++)
			wp[p] = 0;
		// Background words carry their own address
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = {16'hf111, 6'h0, `LC_ADDR_BITS'(a), 16'h5aa5, 6'h0, `LC_ADDR_BITS'(a)};

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Nothing committed yet so the DUT stays silent
		errs_before = error_count;
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			if (rd_en !== 1'b0)
				note_mismatch("rd_en while idle", -1, rd_en, 0);
			if (lookup_en !== 1'b0)
				note_mismatch("lookup_en while idle", -1, lookup_en, 0);
			if (stream_valid !== 1'b0)
				note_mismatch("stream_valid while idle", -1, stream_valid, 0);
		end
		tests_run++;
		if (error_count == errs_before) begin
			$display("test reset_idle: passed");
		end else begin
			tests_failed++;
			$display("test reset_idle: failed");
		end

		total_words = 0;
		for (int e = 0; e < NUM_FRAMES; e++)
			total_words += words_of(frames[e].len) + 1;
		limit_cycles = total_words + 50 * NUM_FRAMES;

		// All rows land on one falling edge, so every port starts together
		@(negedge clk);
		for (int e = 0; e < NUM_FRAMES; e++) begin
			load_frame(e);
			wr_ptr_committed[frames[e].port] = `LC_PTR_BITS'(wp[frames[e].port]);
		end

		wait (frames_done == NUM_FRAMES);

		// No reads or words left over once every frame is out
		errs_before = error_count;
		repeat (20) begin
			@(posedge clk);
			if (rd_en !== 1'b0)
				note_mismatch("rd_en after last frame", -1, rd_en, 0);
			if (stream_valid !== 1'b0)
				note_mismatch("stream_valid after last frame", -1, stream_valid, 0);
		end
		if (lk_due.size() != 0)
			note_problem("lookups still waiting after the last frame", -1);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test all_frames_once: passed");
		end else begin
			tests_failed++;
			$display("test all_frames_once: failed");
		end

		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog sized from the frame table
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d frames forwarded",
			limit_cycles, frames_done, NUM_FRAMES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/lc_reader_pkg.sv
rtl/sync_fifo.sv
rtl/frame_scheduler.sv
rtl/header_parser.sv
rtl/frame_emitter.sv
rtl/lc_fifo_reader.sv
verification/lc_fifo_reader_props.sv
verification/lc_fifo_reader_tb.sv
